// ==== include/mipsCtrl_params.svh ====
`ifndef MIPSCTRL_PARAMS_SVH
`define MIPSCTRL_PARAMS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// control word select widths
`define ALUOP_W 3
`define SRCA_W 2
`define SEL_W 3

// memory address codes of the trap vectors
`define VEC_ILLEGAL 3'd3
`define VEC_OVERFLOW 3'd4

`endif

// ==== rtl/mipsCtrlPkg.sv ====
`default_nettype none

`include "mipsCtrl_params.svh"

package mipsCtrlPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        opR     = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opSxori = 6'h0e,
        opLui   = 6'h0f,
        opRte   = 6'h10,
        opLw    = 6'h23,
        opLbu   = 6'h24,
        opLhu   = 6'h25,
        opSb    = 6'h28,
        opSh    = 6'h29,
        opSw    = 6'h2b
    } opcode_t;

    // function field of the R-type opcode
    typedef enum logic [`FUNCT_W-1:0] {
        fnJr    = 6'h08,
        fnBreak = 6'h0d,
        fnAdd   = 6'h20,
        fnAddu  = 6'h21,
        fnSub   = 6'h22,
        fnSubu  = 6'h23,
        fnAnd   = 6'h24,
        fnXor   = 6'h26,
        fnSlt   = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsSetLess, clsLoadUpper, clsBranch, clsLoad, clsStoreWord,
        clsStorePart, clsJump, clsJumpLink, clsJumpReg, clsReturnExc, clsHalt, clsIllegal
    } instrClass_t;

    typedef enum logic [`ALUOP_W-1:0] {
        aluLoad, aluAdd, aluSub, aluAnd, aluInc, aluNot, aluXor, aluCompare
    } aluOp_t;

    typedef enum logic [1:0] {
        sizeWord = 2'd0,
        sizeByte = 2'd1,
        sizeHalf = 2'd2
    } memSize_t;

    typedef enum logic [`SRCA_W-1:0] {srcAPc, srcAMdr, srcARegA} srcA_t;

    typedef enum logic [`SEL_W-1:0] {srcBRegB, srcBFour, srcBExtend, srcBShiftedOffset} srcB_t;

    typedef enum logic [`SEL_W-1:0] {
        pcAluResult, pcAluOut, pcJumpTarget, pcEpc, pcVector
    } pcSrc_t;

    // trap codes double as the address of the vector byte
    typedef enum logic [`SEL_W-1:0] {
        addrPc           = 3'd0,
        addrAluOut       = 3'd2,
        addrTrapIllegal  = `VEC_ILLEGAL,
        addrTrapOverflow = `VEC_OVERFLOW
    } addrSel_t;

    typedef enum logic [1:0] {destRt, destRd, destRa} regDest_t;

    typedef enum logic [2:0] {
        dataAluOut, dataMdr, dataLessThan, dataUpperImm, dataPc
    } regData_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        logic        usesImmediate;
        memSize_t    memSize;
        logic        trapsOnOverflow;
    } decodedInstr_t;

    typedef struct packed {
        logic equal;
        logic greater;
        logic less;
        logic overflow;
    } aluFlags_t;

    typedef struct packed {
        logic     pcWrite;
        pcSrc_t   pcSrc;
        addrSel_t memAddrSel;
        logic     memWrite;
        memSize_t storeSize;
        logic     writeFromB;
        logic     irWrite;
        logic     mdrLoad;
        memSize_t mdrSize;
        logic     regWrite;
        regDest_t regDest;
        regData_t regData;
        srcA_t    aluSrcA;
        srcB_t    aluSrcB;
        aluOp_t   aluOp;
        logic     aluOutLoad;
        logic     abLoad;
        logic     epcLoad;
        logic     clearRegs;
    } ctrlWord_t;

    typedef enum logic [4:0] {
        stIdle, stResetClear, stFetch, stFetchWait, stDecode, stExecute, stCompare, stCheck,
        stWriteBack, stSetLess, stLoadUpper, stJump, stAddress, stMemRead, stMemWait,
        stMdrLoad, stStore, stTaken, stTrap, stTrapWait, stVector, stHalt
    } seqState_t;

endpackage

`default_nettype wire

// ==== rtl/opDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_params.svh"

module opDecoder (
    input  logic [`OPCODE_W-1:0]       opcode,
    input  logic [`FUNCT_W-1:0]        funct,
    output mipsCtrlPkg::decodedInstr_t decoded
);
    import mipsCtrlPkg::*;

    always_comb begin
        // anything not matched below stays illegal
        decoded = '{instrClass: clsIllegal, aluOp: aluAdd, usesImmediate: 1'b0,
                    memSize: sizeWord, trapsOnOverflow: 1'b0};
        case (opcode)
            opR: begin
                case (funct)
                    fnAdd: begin
                        decoded.instrClass      = clsAluReg;
                        decoded.trapsOnOverflow = 1'b1;
                    end
                    fnAddu: decoded.instrClass = clsAluReg;
                    fnSub: begin
                        decoded.instrClass      = clsAluReg;
                        decoded.aluOp           = aluSub;
                        decoded.trapsOnOverflow = 1'b1;
                    end
                    fnSubu: begin
                        decoded.instrClass = clsAluReg;
                        decoded.aluOp      = aluSub;
                    end
                    fnAnd: begin
                        decoded.instrClass = clsAluReg;
                        decoded.aluOp      = aluAnd;
                    end
                    fnXor: begin
                        decoded.instrClass = clsAluReg;
                        decoded.aluOp      = aluXor;
                    end
                    fnSlt: begin
                        decoded.instrClass = clsSetLess;
                        decoded.aluOp      = aluCompare;
                    end
                    fnJr: begin
                        decoded.instrClass = clsJumpReg;
                        decoded.aluOp      = aluLoad;
                    end
                    fnBreak: decoded.instrClass = clsHalt;
                    default: decoded.instrClass = clsIllegal;
                endcase
            end
            opAddi, opAddiu, opAndi, opSxori: begin
                decoded.instrClass      = clsAluImm;
                decoded.usesImmediate   = 1'b1;
                decoded.trapsOnOverflow = (opcode == opAddi);
                if (opcode == opAndi) begin
                    decoded.aluOp = aluAnd;
                end else if (opcode == opSxori) begin
                    decoded.aluOp = aluXor;
                end
            end
            opSlti: begin
                decoded.instrClass    = clsSetLess;
                decoded.aluOp         = aluCompare;
                decoded.usesImmediate = 1'b1;
            end
            opLui: begin
                decoded.instrClass    = clsLoadUpper;
                decoded.aluOp         = aluLoad;
                decoded.usesImmediate = 1'b1;
            end
            opBeq, opBne, opBle, opBgt: begin
                decoded.instrClass = clsBranch;
                decoded.aluOp      = aluCompare;
            end
            opLw, opLbu, opLhu: begin
                decoded.instrClass    = clsLoad;
                decoded.usesImmediate = 1'b1;
                if (opcode == opLbu) begin
                    decoded.memSize = sizeByte;
                end else if (opcode == opLhu) begin
                    decoded.memSize = sizeHalf;
                end
            end
            opSw: begin
                decoded.instrClass    = clsStoreWord;
                decoded.usesImmediate = 1'b1;
            end
            opSb, opSh: begin
                decoded.instrClass    = clsStorePart;
                decoded.usesImmediate = 1'b1;
                if (opcode == opSb) begin
                    decoded.memSize = sizeByte;
                end else begin
                    decoded.memSize = sizeHalf;
                end
            end
            opJ: decoded.instrClass = clsJump;
            opJal: decoded.instrClass = clsJumpLink;
            opRte: decoded.instrClass = clsReturnExc;
            default: decoded.instrClass = clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/conditionUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_params.svh"

module conditionUnit (
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`FUNCT_W-1:0]    funct,
    input  mipsCtrlPkg::aluFlags_t flags,
    output logic                   takeBranch,
    output logic                   overflowTrap
);
    import mipsCtrlPkg::*;

    logic signedArith;

    // one rule per branch opcode
    always_comb begin
        case (opcode)
            opBeq: takeBranch = flags.equal;
            opBne: takeBranch = !flags.equal;
            opBle: takeBranch = !flags.greater;
            opBgt: takeBranch = flags.greater;
            default: takeBranch = 1'b0;
        endcase
    end

    // only the signed adds and subtracts trap
    always_comb begin
        signedArith = 1'b0;
        if (opcode == opAddi) begin
            signedArith = 1'b1;
        end else if (opcode == opR) begin
            signedArith = (funct == fnAdd) || (funct == fnSub);
        end
    end

    assign overflowTrap = flags.overflow && signedArith;

endmodule

`default_nettype wire

// ==== rtl/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic                       clk,
    input  logic                       arstN,
    input  mipsCtrlPkg::decodedInstr_t decoded,
    input  logic                       takeBranch,
    input  logic                       overflowTrap,
    output mipsCtrlPkg::ctrlWord_t     ctrl
);
    import mipsCtrlPkg::*;

    seqState_t state;
    seqState_t nextState;
    ctrlWord_t ctrlNext;
    addrSel_t  trapAddr;

    assign trapAddr = decoded.trapsOnOverflow ? addrTrapOverflow : addrTrapIllegal;

    always_comb begin
        nextState = stFetch;
        case (state)
            stIdle: nextState = stResetClear;
            stResetClear: nextState = stFetch;
            stFetch: nextState = stFetchWait;
            stFetchWait: nextState = stDecode;
            stDecode: begin
                case (decoded.instrClass)
                    clsAluReg, clsAluImm: nextState = stExecute;
                    clsSetLess: nextState = stSetLess;
                    clsLoadUpper: nextState = stLoadUpper;
                    clsBranch: nextState = stCompare;
                    clsLoad, clsStoreWord, clsStorePart: nextState = stAddress;
                    clsJump, clsJumpLink, clsJumpReg, clsReturnExc: nextState = stJump;
                    clsHalt: nextState = stHalt;
                    default: nextState = stTrap;
                endcase
            end
            stExecute, stCompare: nextState = stCheck;
            // flags are stable here
            stCheck: begin
                if (decoded.instrClass == clsBranch) begin
                    nextState = takeBranch ? stTaken : stFetch;
                end else begin
                    nextState = overflowTrap ? stTrap : stWriteBack;
                end
            end
            stAddress: begin
                if (decoded.instrClass == clsStoreWord) begin
                    nextState = stStore;
                end else begin
                    nextState = stMemRead;
                end
            end
            stMemRead: nextState = stMemWait;
            stMemWait: nextState = stMdrLoad;
            stMdrLoad: begin
                if (decoded.instrClass == clsLoad) begin
                    nextState = stWriteBack;
                end else begin
                    nextState = stStore;
                end
            end
            stTrap: nextState = stTrapWait;
            stTrapWait: nextState = stVector;
            stHalt: nextState = stHalt;
            default: nextState = stFetch;
        endcase
    end

    // control word of the state being entered
    always_comb begin
        ctrlNext = '0;
        case (nextState)
            stResetClear: ctrlNext.clearRegs = 1'b1;
            stFetch: begin
                ctrlNext.pcWrite    = 1'b1;
                ctrlNext.pcSrc      = pcAluResult;
                ctrlNext.memAddrSel = addrPc;
                ctrlNext.aluSrcA    = srcAPc;
                ctrlNext.aluSrcB    = srcBFour;
                ctrlNext.aluOp      = aluAdd;
            end
            stFetchWait: begin
                ctrlNext.irWrite    = 1'b1;
                ctrlNext.memAddrSel = addrPc;
            end
            stDecode: begin
                // branch target goes to aluOut early
                ctrlNext.abLoad     = 1'b1;
                ctrlNext.aluOutLoad = 1'b1;
                ctrlNext.aluSrcA    = srcAPc;
                ctrlNext.aluSrcB    = srcBShiftedOffset;
                ctrlNext.aluOp      = aluAdd;
            end
            stExecute, stCompare, stCheck, stSetLess: begin
                ctrlNext.aluSrcA    = srcARegA;
                ctrlNext.aluSrcB    = decoded.usesImmediate ? srcBExtend : srcBRegB;
                ctrlNext.aluOp      = decoded.aluOp;
                ctrlNext.aluOutLoad = (nextState == stExecute);
                if (nextState == stSetLess) begin
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.regData  = dataLessThan;
                    ctrlNext.regDest  = decoded.usesImmediate ? destRt : destRd;
                end
            end
            stWriteBack: begin
                ctrlNext.regWrite = 1'b1;
                ctrlNext.regDest  = decoded.usesImmediate ? destRt : destRd;
                if (decoded.instrClass == clsLoad) begin
                    ctrlNext.regData = dataMdr;
                end else begin
                    ctrlNext.regData = dataAluOut;
                end
            end
            stLoadUpper: begin
                ctrlNext.regWrite = 1'b1;
                ctrlNext.regDest  = destRt;
                ctrlNext.regData  = dataUpperImm;
            end
            stJump: begin
                ctrlNext.pcWrite = 1'b1;
                case (decoded.instrClass)
                    clsJumpLink: begin
                        ctrlNext.pcSrc    = pcJumpTarget;
                        ctrlNext.regWrite = 1'b1;
                        ctrlNext.regDest  = destRa;
                        ctrlNext.regData  = dataPc;
                    end
                    clsJumpReg: begin
                        // register A passes straight through the ALU
                        ctrlNext.pcSrc   = pcAluResult;
                        ctrlNext.aluSrcA = srcARegA;
                        ctrlNext.aluOp   = aluLoad;
                    end
                    clsReturnExc: ctrlNext.pcSrc = pcEpc;
                    default: ctrlNext.pcSrc = pcJumpTarget;
                endcase
            end
            stAddress: begin
                ctrlNext.aluSrcA    = srcARegA;
                ctrlNext.aluSrcB    = srcBExtend;
                ctrlNext.aluOp      = aluAdd;
                ctrlNext.aluOutLoad = 1'b1;
            end
            stMemRead, stMemWait: ctrlNext.memAddrSel = addrAluOut;
            stMdrLoad: begin
                ctrlNext.memAddrSel = addrAluOut;
                ctrlNext.mdrLoad    = 1'b1;
                // partial stores merge into the full word
                if (decoded.instrClass == clsLoad) begin
                    ctrlNext.mdrSize = decoded.memSize;
                end else begin
                    ctrlNext.mdrSize = sizeWord;
                end
            end
            stStore: begin
                ctrlNext.memAddrSel = addrAluOut;
                ctrlNext.memWrite   = 1'b1;
                ctrlNext.storeSize  = decoded.memSize;
                ctrlNext.writeFromB = (decoded.instrClass == clsStoreWord);
            end
            stTaken: begin
                ctrlNext.pcWrite = 1'b1;
                ctrlNext.pcSrc   = pcAluOut;
            end
            stTrap: begin
                // epc gets pc - 4
                ctrlNext.epcLoad    = 1'b1;
                ctrlNext.aluSrcA    = srcAPc;
                ctrlNext.aluSrcB    = srcBFour;
                ctrlNext.aluOp      = aluSub;
                ctrlNext.memAddrSel = trapAddr;
            end
            stTrapWait: ctrlNext.memAddrSel = trapAddr;
            stVector: begin
                ctrlNext.memAddrSel = trapAddr;
                ctrlNext.pcWrite    = 1'b1;
                ctrlNext.pcSrc      = pcVector;
                ctrlNext.mdrSize    = sizeByte;
            end
            default: ctrlNext = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            ctrl  <= '0;
        end else begin
            state <= nextState;
            ctrl  <= ctrlNext;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_params.svh"

module controlUnit (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`FUNCT_W-1:0]    funct,
    input  mipsCtrlPkg::aluFlags_t flags,
    output mipsCtrlPkg::ctrlWord_t ctrl
);
    import mipsCtrlPkg::*;

    decodedInstr_t decoded;
    logic          takeBranch;
    logic          overflowTrap;

    opDecoder decoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    // evaluates the flags of the current instruction
    conditionUnit conditions (
        .opcode       (opcode),
        .funct        (funct),
        .flags        (flags),
        .takeBranch   (takeBranch),
        .overflowTrap (overflowTrap)
    );

    controlSequencer sequencer (
        .clk          (clk),
        .arstN        (arstN),
        .decoded      (decoded),
        .takeBranch   (takeBranch),
        .overflowTrap (overflowTrap),
        .ctrl         (ctrl)
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // falling arstN starts the asynchronous reset
    initial begin
        arstN = 1'b1;
        #1 arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/controlUnit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit_assert (
    input logic                   clk,
    input logic                   arstN,
    input mipsCtrlPkg::ctrlWord_t ctrl,
    input mipsCtrlPkg::seqState_t state
);
    import mipsCtrlPkg::*;

    // a store and a register write never share a cycle
    noStoreWithRegWrite: assert property (@(posedge clk) disable iff (!arstN)
        !(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite are high in the same cycle");

    quietInReset: assert property (@(posedge clk) !arstN |-> ctrl == '0)
        else $error("control word is not cleared while arstN is low");

    // instruction register loads right after the fetch pulse
    irAfterFetch: assert property (@(posedge clk) disable iff (!arstN)
        (state == stFetch && ctrl.pcWrite && !ctrl.irWrite) |=> ctrl.irWrite)
        else $error("irWrite did not follow the fetch pulse");

endmodule

bind controlSequencer controlUnit_assert sequencerChecks (
    .clk   (clk),
    .arstN (arstN),
    .ctrl  (ctrl),
    .state (state)
);

`default_nettype wire

// ==== sim/controlUnit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsCtrl_params.svh"

module controlUnit_tb;
    import mipsCtrlPkg::*;

    // watchdog budget, counted in instruction runs
    localparam int testCount     = 44;
    localparam int cyclesPerTest = 60;
    localparam int resetCycles   = 16;
    localparam int maxSeqLen     = 30;

    typedef enum {regWritePulse, memWritePulse, mdrLoadPulse, epcLoadPulse} pulse_t;

    logic                 clk;
    logic                 arstN;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    aluFlags_t            flags;
    ctrlWord_t            ctrl;

    int        errors;
    integer    seed;
    // words from fetchWait up to and including the next fetch
    ctrlWord_t trace[$];

    clockGen #(.resetCycles(resetCycles)) clocks (
        .clk   (clk),
        .arstN (arstN)
    );

    controlUnit dut (
        .clk    (clk),
        .arstN  (arstN),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    function automatic logic isFetch(input ctrlWord_t word);
        return word.pcWrite && !word.irWrite && word.pcSrc == pcAluResult &&
               word.aluSrcB == srcBFour;
    endfunction

    // first state before the closing fetch that carries the pulse
    function automatic int findPulse(input pulse_t which);
        int   idx;
        logic hit;
        idx = -1;
        for (int i = 0; i + 1 < trace.size(); i++) begin
            case (which)
                regWritePulse: hit = trace[i].regWrite;
                memWritePulse: hit = trace[i].memWrite;
                mdrLoadPulse:  hit = trace[i].mdrLoad;
                default:       hit = trace[i].epcLoad;
            endcase
            if (hit && idx < 0) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic mismatch(input string name, input string expected, input string actual);
        errors++;
        $display("Mismatch in %s: expected %s, actual %s", name, expected, actual);
    endtask

    task automatic failure(input string text);
        errors++;
        $display("Error: %s", text);
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatch(name, $sformatf("%0d cycles", expected), $sformatf("%0d cycles", actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
        end
    endtask

    task automatic checkWord(input string name, input ctrlWord_t expected,
                             input ctrlWord_t actual);
        if (expected !== actual) begin
            mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
        end
    endtask

    task automatic checkAluOp(input string name, input aluOp_t expected, input aluOp_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    task automatic checkPcSrc(input string name, input pcSrc_t expected, input pcSrc_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    task automatic checkSrcB(input string name, input srcB_t expected, input srcB_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    task automatic checkAddrSel(input string name, input addrSel_t expected,
                                input addrSel_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    task automatic checkRegDest(input string name, input regDest_t expected,
                                input regDest_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    task automatic checkSize(input string name, input memSize_t expected,
                             input memSize_t actual);
        if (expected !== actual) begin
            mismatch(name, expected.name(), actual.name());
        end
    endtask

    // entered and left on the falling edge that shows a fetch pulse
    task automatic runInstr(input string name, input logic [`OPCODE_W-1:0] op,
                            input logic [`FUNCT_W-1:0] fn, input aluFlags_t fl,
                            output int seqLen);
        logic found;
        opcode = op;
        funct  = fn;
        flags  = fl;
        trace.delete();
        found = 1'b0;
        while (!found && trace.size() < maxSeqLen) begin
            @(negedge clk);
            trace.push_back(ctrl);
            found = isFetch(ctrl);
        end
        seqLen = trace.size();
        if (!found) begin
            failure($sformatf("%s: no fetch pulse within %0d cycles", name, maxSeqLen));
        end
    endtask

    task automatic testReset();
        int clearCycles;
        int waited;
        clearCycles = 0;
        waited = 0;
        @(negedge clk);
        checkWord("reset held", '0, ctrl);
        wait (arstN);
        // first pcWrite after reset is the fetch pulse
        while (!ctrl.pcWrite && waited < maxSeqLen) begin
            @(negedge clk);
            waited++;
            if (ctrl.clearRegs) begin
                clearCycles++;
            end
        end
        checkCycles("reset clearRegs", 1, clearCycles);
        if (!ctrl.pcWrite) begin
            failure("no fetch pulse after reset");
        end else begin
            checkBit("reset fetch irWrite", 1'b0, ctrl.irWrite);
            checkAluOp("reset fetch aluOp", aluAdd, ctrl.aluOp);
            checkSrcB("reset fetch aluSrcB", srcBFour, ctrl.aluSrcB);
        end
    endtask

    task automatic aluCase(input string name, input logic [`OPCODE_W-1:0] op,
                           input logic [`FUNCT_W-1:0] fn, input aluOp_t expOp,
                           input logic immediate, input int expLen);
        int seqLen;
        int idx;
        runInstr(name, op, fn, '0, seqLen);
        checkCycles(name, expLen, seqLen);
        // fetchWait and decode come first
        if (trace.size() > 2) begin
            checkAluOp({name, " aluOp"}, expOp, trace[2].aluOp);
        end
        idx = findPulse(regWritePulse);
        if (idx < 0) begin
            failure({name, ": no register write"});
        end else begin
            checkRegDest({name, " regDest"}, immediate ? destRt : destRd, trace[idx].regDest);
        end
    endtask

    task automatic testAluOps();
        aluCase("add", opR, fnAdd, aluAdd, 1'b0, 6);
        aluCase("addu", opR, fnAddu, aluAdd, 1'b0, 6);
        aluCase("sub", opR, fnSub, aluSub, 1'b0, 6);
        aluCase("subu", opR, fnSubu, aluSub, 1'b0, 6);
        aluCase("and", opR, fnAnd, aluAnd, 1'b0, 6);
        aluCase("xor", opR, fnXor, aluXor, 1'b0, 6);
        aluCase("slt", opR, fnSlt, aluCompare, 1'b0, 4);
        aluCase("addi", opAddi, '0, aluAdd, 1'b1, 6);
        aluCase("addiu", opAddiu, '0, aluAdd, 1'b1, 6);
        aluCase("andi", opAndi, '0, aluAnd, 1'b1, 6);
        aluCase("sxori", opSxori, '0, aluXor, 1'b1, 6);
        aluCase("slti", opSlti, '0, aluCompare, 1'b1, 4);
        aluCase("lui", opLui, '0, aluLoad, 1'b1, 4);
    endtask

    task automatic branchCase(input string name, input opcode_t op);
        logic [31:0] draw;
        aluFlags_t   fl;
        logic        taken;
        int          seqLen;
        string       testName;
        for (int i = 0; i < 4; i++) begin
            draw = $random(seed);
            fl = draw[3:0];
            case (op)
                opBeq: taken = fl.equal;
                opBne: taken = !fl.equal;
                opBle: taken = !fl.greater;
                default: taken = fl.greater;
            endcase
            testName = $sformatf("%s flags %b", name, fl);
            runInstr(testName, op, '0, fl, seqLen);
            checkCycles(testName, taken ? 6 : 5, seqLen);
            if (taken && seqLen == 6) begin
                checkBit({testName, " pcWrite"}, 1'b1, trace[4].pcWrite);
                checkPcSrc({testName, " pcSrc"}, pcAluOut, trace[4].pcSrc);
            end
        end
    endtask

    task automatic testBranches();
        branchCase("beq", opBeq);
        branchCase("bne", opBne);
        branchCase("ble", opBle);
        branchCase("bgt", opBgt);
    endtask

    task automatic loadCase(input string name, input opcode_t op, input memSize_t expSize);
        int seqLen;
        int idx;
        runInstr(name, op, '0, '0, seqLen);
        checkCycles(name, 8, seqLen);
        idx = findPulse(mdrLoadPulse);
        if (idx < 0) begin
            failure({name, ": no MDR load"});
        end else begin
            checkSize({name, " mdrSize"}, expSize, trace[idx].mdrSize);
        end
        if (findPulse(regWritePulse) < 0) begin
            failure({name, ": no register write"});
        end
    endtask

    task automatic storeCase(input string name, input opcode_t op, input memSize_t expSize,
                             input int expLen);
        int seqLen;
        int idx;
        runInstr(name, op, '0, '0, seqLen);
        checkCycles(name, expLen, seqLen);
        idx = findPulse(memWritePulse);
        if (idx < 0) begin
            failure({name, ": no memory write"});
        end else begin
            checkSize({name, " storeSize"}, expSize, trace[idx].storeSize);
            checkBit({name, " writeFromB"}, expSize == sizeWord, trace[idx].writeFromB);
        end
    endtask

    task automatic testMemory();
        loadCase("lw", opLw, sizeWord);
        loadCase("lbu", opLbu, sizeByte);
        loadCase("lhu", opLhu, sizeHalf);
        storeCase("sw", opSw, sizeWord, 5);
        storeCase("sb", opSb, sizeByte, 8);
        storeCase("sh", opSh, sizeHalf, 8);
    endtask

    task automatic jumpCase(input string name, input logic [`OPCODE_W-1:0] op,
                            input logic [`FUNCT_W-1:0] fn, input pcSrc_t expPc,
                            input logic link);
        int seqLen;
        runInstr(name, op, fn, '0, seqLen);
        checkCycles(name, 4, seqLen);
        if (trace.size() > 2) begin
            checkBit({name, " pcWrite"}, 1'b1, trace[2].pcWrite);
            checkPcSrc({name, " pcSrc"}, expPc, trace[2].pcSrc);
            checkBit({name, " regWrite"}, link, trace[2].regWrite);
            if (link) begin
                checkRegDest({name, " regDest"}, destRa, trace[2].regDest);
            end
            if (expPc == pcAluResult) begin
                checkAluOp({name, " aluOp"}, aluLoad, trace[2].aluOp);
            end
        end
    endtask

    task automatic testJumps();
        jumpCase("j", opJ, '0, pcJumpTarget, 1'b0);
        jumpCase("jal", opJal, '0, pcJumpTarget, 1'b1);
        jumpCase("jr", opR, fnJr, pcAluResult, 1'b0);
        jumpCase("rte", opRte, '0, pcEpc, 1'b0);
    endtask

    task automatic trapCase(input string name, input logic [`OPCODE_W-1:0] op,
                            input logic [`FUNCT_W-1:0] fn, input aluFlags_t fl,
                            input addrSel_t expAddr, input int expLen);
        int seqLen;
        int idx;
        runInstr(name, op, fn, fl, seqLen);
        checkCycles(name, expLen, seqLen);
        idx = findPulse(epcLoadPulse);
        if (idx < 0) begin
            failure({name, ": no EPC load"});
        end else begin
            checkAddrSel({name, " memAddrSel"}, expAddr, trace[idx].memAddrSel);
        end
        if (seqLen >= 2) begin
            checkBit({name, " vector pcWrite"}, 1'b1, trace[seqLen-2].pcWrite);
            checkPcSrc({name, " vector pcSrc"}, pcVector, trace[seqLen-2].pcSrc);
        end
    endtask

    task automatic testTraps();
        aluFlags_t ovf;
        ovf = '0;
        ovf.overflow = 1'b1;
        trapCase("unknown opcode", 6'h3f, '0, '0, addrTrapIllegal, 6);
        // overflow is only seen in check, after execute
        trapCase("add overflow", opR, fnAdd, ovf, addrTrapOverflow, 8);
        trapCase("addi overflow", opAddi, '0, ovf, addrTrapOverflow, 8);
    endtask

    task automatic testBreak();
        opcode = opR;
        funct  = fnBreak;
        flags  = '0;
        // fetchWait and decode still carry control bits
        repeat (2) @(negedge clk);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            checkWord($sformatf("break cycle %0d", i), '0, ctrl);
        end
    endtask

    initial begin
        errors = 0;
        seed   = 32'he8f4_095e;
        opcode = '0;
        funct  = '0;
        flags  = '0;
        testReset();
        testAluOps();
        testBranches();
        testMemory();
        testJumps();
        testTraps();
        testBreak();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (resetCycles + testCount * cyclesPerTest) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 resetCycles + testCount * cyclesPerTest);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsCtrl.f ====
+incdir+include
rtl/mipsCtrlPkg.sv
rtl/opDecoder.sv
rtl/conditionUnit.sv
rtl/controlSequencer.sv
rtl/controlUnit.sv
sim/clockGen.sv
sim/controlUnit_assert.sv
sim/controlUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds with Verilator, runs, and passes only on the testbench's success line
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module controlUnit_tb -f mipsCtrl.f &&
    ./obj_dir/VcontrolUnit_tb | tee /dev/stderr | grep -qx "Everything OK" &&
    echo "PASS" || { echo "FAIL"; exit 1; }
